// File: Bender.yml
package:
  name: egr_mesh_rd

sources:
  # Package first, then leaf modules, then the top level
  - files:
      - logic/mesh_rd_pkg.sv
      - logic/rd_fifo.sv
      - logic/mesh_rd_unit.sv
      - logic/mesh_mem_bank.sv
      - logic/egr_mesh_rd_top.sv

  # Testbench, top module tb_mesh_rd
  - target: test
    files:
      - bench/tb_mesh_rd.sv

// File: bench/mesh_rd_stim.txt
# W ptr wd sema data : preload word, hex fields, data * takes the next LCG word
# R ptr wd sema id : read request; G n : n idle cycles; T name : start a test
T preload_read
W 10 0 1 0123456789abcdef
W 10 1 1 *
W 10 2 1 *
W 10 3 1 fedcba9876543210
W 2a 0 2 *
W 2a 1 2 *
G 2
R 10 0 1 01
R 10 3 1 02
G 3
R 2a 1 2 03
R 2a 0 2 04
T bad_sema
R 10 1 2 05
R 2a 0 0 06
R 10 2 1 07
T isolated
G 20
R 10 2 1 08
G 4
T burst
W 33 0 3 *
W 33 1 3 *
W 33 2 3 *
W 33 3 3 *
W 44 0 0 *
W 44 1 0 *
R 33 0 3 10
R 33 1 3 11
R 44 0 0 12
R 33 2 3 13
R 33 3 3 14
R 44 1 0 15
R 10 0 1 16
R 2a 1 2 17
R 33 0 1 18
R 44 0 0 19
T rewrite
W 10 1 3 *
R 10 1 1 20
R 10 1 3 21
R 10 0 1 22
R 10 0 3 23

// File: bench/tb_mesh_rd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mesh_rd;

    import mesh_rd_pkg::*;

    localparam string STIM_FILE = "bench/mesh_rd_stim.txt";
    localparam int    RSP_LAT   = 7;            // Isolated read latency from strobe to response

    //////////////////////////////
    // DUT signals
    //////////////////////////////
    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 rreq_valid;
    logic [W_SEG_PTR-1:0] rreq_seg_ptr;
    logic [W_SEMA-1:0]    rreq_sema;
    logic [W_WD_SEL-1:0]  rreq_wd_sel;
    logic [W_REQ_ID-1:0]  rreq_id;
    logic                 rreq_full;
    logic                 mem_wr_en;
    logic [W_SEG_PTR-1:0] mem_wr_seg_ptr;
    logic [W_WD_SEL-1:0]  mem_wr_wd_sel;
    logic [W_SEMA-1:0]    mem_wr_sema;
    logic [W_WORD-1:0]    mem_wr_data;
    logic                 tqu_rsp_valid;
    logic [W_WORD-1:0]    tqu_rsp_data;
    logic [W_REQ_ID-1:0]  tqu_rsp_id;
    logic                 tqu_rsp_err;
    logic                 prc_rsp_valid;
    logic [W_REQ_ID-1:0]  prc_rsp_id;

    egr_mesh_rd_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .rreq_valid     (rreq_valid),
        .rreq_seg_ptr   (rreq_seg_ptr),
        .rreq_sema      (rreq_sema),
        .rreq_wd_sel    (rreq_wd_sel),
        .rreq_id        (rreq_id),
        .rreq_full      (rreq_full),
        .mem_wr_en      (mem_wr_en),
        .mem_wr_seg_ptr (mem_wr_seg_ptr),
        .mem_wr_wd_sel  (mem_wr_wd_sel),
        .mem_wr_sema    (mem_wr_sema),
        .mem_wr_data    (mem_wr_data),
        .tqu_rsp_valid  (tqu_rsp_valid),
        .tqu_rsp_data   (tqu_rsp_data),
        .tqu_rsp_id     (tqu_rsp_id),
        .tqu_rsp_err    (tqu_rsp_err),
        .prc_rsp_valid  (prc_rsp_valid),
        .prc_rsp_id     (prc_rsp_id)
    );

    always #10 clk = ~clk;                      // 20 ns period

    //////////////////////////////
    // Reference model and bookkeeping
    //////////////////////////////
    logic [W_WORD-1:0]   ref_mem  [N_MEM_WORDS];
    logic [W_SEMA-1:0]   ref_sema [N_SEGS];     // Cleared like the bank at reset
    logic [W_WORD-1:0]   exp_data_q [$];
    logic [W_REQ_ID-1:0] exp_id_q   [$];
    logic                exp_err_q  [$];
    int                  exp_cyc_q  [$];        // Strobe cycle or -1 when latency varies

    string       stim_lines [$];
    string       cur_test = "";
    int          cyc = 0;                       // Counts sampling points
    int          max_cyc = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          test_reads = 0;
    int          tests_run = 0;
    int          total_reads = 0;
    logic [31:0] lcg_state;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic note_error;
        errors++;
        test_errors++;
    endtask

    // Response checks against the head of the expected queue
    task automatic check_outputs;
        logic [W_WORD-1:0]   exp_data;
        logic [W_REQ_ID-1:0] exp_id;
        logic                exp_err;
        int                  exp_cyc;
        assert (prc_rsp_valid === tqu_rsp_valid) else begin
            $display("[ERROR] prc_rsp_valid = %h, expected %h", prc_rsp_valid, tqu_rsp_valid);
            note_error();
        end
        if (tqu_rsp_valid === 1'b1) begin
            if (exp_id_q.size() == 0) begin
                $display("Response with ID %h arrived with no read outstanding", tqu_rsp_id);
                note_error();
            end else begin
                exp_data = exp_data_q.pop_front();
                exp_id   = exp_id_q.pop_front();
                exp_err  = exp_err_q.pop_front();
                exp_cyc  = exp_cyc_q.pop_front();
                test_reads++;
                assert (tqu_rsp_data === exp_data) else begin
                    $display("[ERROR] tqu_rsp_data = %h, expected %h", tqu_rsp_data, exp_data);
                    note_error();
                end
                assert (tqu_rsp_id === exp_id) else begin
                    $display("[ERROR] tqu_rsp_id = %h, expected %h", tqu_rsp_id, exp_id);
                    note_error();
                end
                assert (tqu_rsp_err === exp_err) else begin
                    $display("[ERROR] tqu_rsp_err = %h, expected %h", tqu_rsp_err, exp_err);
                    note_error();
                end
                assert (prc_rsp_id === exp_id) else begin
                    $display("[ERROR] prc_rsp_id = %h, expected %h", prc_rsp_id, exp_id);
                    note_error();
                end
                if (exp_cyc >= 0) begin
                    assert (cyc - exp_cyc == RSP_LAT) else begin
                        $display("Read %h answered %0d cycles after its strobe, not %0d",
                                 exp_id, cyc - exp_cyc, RSP_LAT);
                        note_error();
                    end
                end
            end
        end
    endtask

    // One sampling point per cycle at the falling edge
    task automatic sample_cycle;
        @(negedge clk);
        cyc++;
        check_outputs();
    endtask

    //////////////////////////////
    // One-cycle drivers
    //////////////////////////////
    task automatic idle_cycle;
        sample_cycle();
        @(posedge clk);
        rreq_valid <= 1'b0;
        mem_wr_en  <= 1'b0;
    endtask

    task automatic write_word(input logic [W_SEG_PTR-1:0] ptr, input logic [W_WD_SEL-1:0] wd,
                              input logic [W_SEMA-1:0] sema, input logic [W_WORD-1:0] data);
        sample_cycle();
        ref_mem[{ptr, wd}] = data;
        ref_sema[ptr]      = sema;              // Any write restamps the segment
        @(posedge clk);
        rreq_valid     <= 1'b0;
        mem_wr_en      <= 1'b1;
        mem_wr_seg_ptr <= ptr;
        mem_wr_wd_sel  <= wd;
        mem_wr_sema    <= sema;
        mem_wr_data    <= data;
    endtask

    task automatic read_word(input logic [W_SEG_PTR-1:0] ptr, input logic [W_WD_SEL-1:0] wd,
                             input logic [W_SEMA-1:0] sema, input logic [W_REQ_ID-1:0] id);
        logic hit;
        logic isolated;
        sample_cycle();
        while (rreq_full === 1'b1) begin    // Hold the strobe while the FIFO is full
            @(posedge clk);
            rreq_valid <= 1'b0;
            mem_wr_en  <= 1'b0;
            sample_cycle();
        end
        hit      = (sema == ref_sema[ptr]);
        isolated = (exp_id_q.size() == 0);  // Nothing queued ahead of it
        exp_data_q.push_back(hit ? ref_mem[{ptr, wd}] : '0);
        exp_id_q.push_back(id);
        exp_err_q.push_back(!hit);
        exp_cyc_q.push_back(isolated ? cyc + 1 : -1);
        @(posedge clk);
        mem_wr_en    <= 1'b0;
        rreq_valid   <= 1'b1;
        rreq_seg_ptr <= ptr;
        rreq_wd_sel  <= wd;
        rreq_sema    <= sema;
        rreq_id      <= id;
    endtask

    // Drain outstanding reads, then report the test
    task automatic finish_test;
        if (cur_test != "") begin
            while (exp_id_q.size() != 0) begin
                idle_cycle();
            end
            $display("Test %-14s %0d responses checked, %0d errors",
                     cur_test, test_reads, test_errors);
            tests_run++;
            total_reads += test_reads;
        end
        cur_test    = "";
        test_reads  = 0;
        test_errors = 0;
    endtask

    //////////////////////////////
    // Stimulus file
    //////////////////////////////
    task automatic load_stim;
        int    fd;
        string line;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file %s", STIM_FILE);
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                stim_lines.push_back(line);
            end
            $fclose(fd);
        end
    endtask

    task automatic run_line(input string line);
        string             kind;
        string             tok;
        logic [31:0]       f1;
        logic [31:0]       f2;
        logic [31:0]       f3;
        logic [W_WORD-1:0] data;
        int                n;
        n = $sscanf(line, "%s", kind);
        if (n < 1 || kind.substr(0, 0) == "#") begin
            return;                             // Blank or comment
        end
        case (kind)
            "T": begin
                n = $sscanf(line, "%s %s", kind, tok);
                finish_test();
                cur_test = tok;
            end
            "W": begin
                n = $sscanf(line, "%s %h %h %h %s", kind, f1, f2, f3, tok);
                if (tok == "*") begin
                    lcg_state    = lcg_next(lcg_state);
                    data[63:32]  = lcg_state;
                    lcg_state    = lcg_next(lcg_state);
                    data[31:0]   = lcg_state;
                end else begin
                    n = $sscanf(tok, "%h", data);
                end
                write_word(f1[W_SEG_PTR-1:0], f2[W_WD_SEL-1:0], f3[W_SEMA-1:0], data);
            end
            "R": begin
                n = $sscanf(line, "%s %h %h %h %h", kind, f1, f2, f3, data);
                read_word(f1[W_SEG_PTR-1:0], f2[W_WD_SEL-1:0], f3[W_SEMA-1:0],
                          data[W_REQ_ID-1:0]);
            end
            "G": begin
                n = $sscanf(line, "%s %d", kind, f1);
                repeat (f1) idle_cycle();
            end
            default: begin
                $display("Stimulus line not understood: %s", line);
                note_error();
            end
        endcase
    endtask

    //////////////////////////////
    // Run limit
    //////////////////////////////
    initial begin
        wait (max_cyc > 0 && cyc > max_cyc);
        $display("Timeout after %0d cycles, %0d reads still outstanding",
                 cyc, exp_id_q.size());
        $display("Done: errors found");
        $finish;
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        rst_n          <= 1'b0;
        rreq_valid     <= 1'b0;
        rreq_seg_ptr   <= '0;
        rreq_sema      <= '0;
        rreq_wd_sel    <= '0;
        rreq_id        <= '0;
        mem_wr_en      <= 1'b0;
        mem_wr_seg_ptr <= '0;
        mem_wr_wd_sel  <= '0;
        mem_wr_sema    <= '0;
        mem_wr_data    <= '0;
        lcg_state = 32'he9f114d3;
        for (int s = 0; s < N_SEGS; s++) begin
            ref_sema[s] = '0;
        end
        load_stim();
        max_cyc = 10 * stim_lines.size() + 100;   // Budget from stimulus length
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Quiet outputs straight out of reset
        cur_test = "reset";
        sample_cycle();
        assert (tqu_rsp_valid === 1'b0) else begin
            $display("[ERROR] tqu_rsp_valid = %h, expected 0", tqu_rsp_valid);
            note_error();
        end
        assert (prc_rsp_valid === 1'b0) else begin
            $display("[ERROR] prc_rsp_valid = %h, expected 0", prc_rsp_valid);
            note_error();
        end
        assert (rreq_full === 1'b0) else begin
            $display("[ERROR] rreq_full = %h, expected 0", rreq_full);
            note_error();
        end
        finish_test();

        foreach (stim_lines[i]) begin
            run_line(stim_lines[i]);
        end
        finish_test();
        repeat (4) idle_cycle();                // Catch any stray response

        $display("%0d tests, %0d responses checked, %0d errors", tests_run, total_reads, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : tb_mesh_rd

`default_nettype wire

// File: logic/egr_mesh_rd_top.sv
`timescale 1ns/1ps
`default_nettype none

module egr_mesh_rd_top (
    input  logic                              clk,
    input  logic                              rst_n,

    // Controller request side
    input  logic                              rreq_valid,
    input  logic [mesh_rd_pkg::W_SEG_PTR-1:0] rreq_seg_ptr,
    input  logic [mesh_rd_pkg::W_SEMA-1:0]    rreq_sema,
    input  logic [mesh_rd_pkg::W_WD_SEL-1:0]  rreq_wd_sel,
    input  logic [mesh_rd_pkg::W_REQ_ID-1:0]  rreq_id,
    output logic                              rreq_full,

    // Memory preload
    input  logic                              mem_wr_en,
    input  logic [mesh_rd_pkg::W_SEG_PTR-1:0] mem_wr_seg_ptr,
    input  logic [mesh_rd_pkg::W_WD_SEL-1:0]  mem_wr_wd_sel,
    input  logic [mesh_rd_pkg::W_SEMA-1:0]    mem_wr_sema,
    input  logic [mesh_rd_pkg::W_WORD-1:0]    mem_wr_data,

    // Responses
    output logic                              tqu_rsp_valid,
    output logic [mesh_rd_pkg::W_WORD-1:0]    tqu_rsp_data,
    output logic [mesh_rd_pkg::W_REQ_ID-1:0]  tqu_rsp_id,
    output logic                              tqu_rsp_err,
    output logic                              prc_rsp_valid,
    output logic [mesh_rd_pkg::W_REQ_ID-1:0]  prc_rsp_id
);

    import mesh_rd_pkg::*;

    // Internal mesh port
    logic                 mim_rreq_valid;
    logic [W_SEG_PTR-1:0] mim_seg_ptr;
    logic [W_SEMA-1:0]    mim_sema;
    logic [W_WD_SEL-1:0]  mim_wd_sel;
    logic [W_REQ_ID-1:0]  mim_req_id;
    logic                 mim_rrsp_valid;
    logic [W_WORD-1:0]    mim_rd_data;
    logic [W_REQ_ID-1:0]  mim_rrsp_req_id;
    logic                 mim_rrsp_err;

    mesh_rd_unit i_rd_unit (
        .clk             (clk),
        .rst_n           (rst_n),
        .rreq_valid      (rreq_valid),
        .rreq_seg_ptr    (rreq_seg_ptr),
        .rreq_sema       (rreq_sema),
        .rreq_wd_sel     (rreq_wd_sel),
        .rreq_id         (rreq_id),
        .rreq_full       (rreq_full),
        .mim_rreq_valid  (mim_rreq_valid),
        .mim_seg_ptr     (mim_seg_ptr),
        .mim_sema        (mim_sema),
        .mim_wd_sel      (mim_wd_sel),
        .mim_req_id      (mim_req_id),
        .mim_rrsp_valid  (mim_rrsp_valid),
        .mim_rd_data     (mim_rd_data),
        .mim_rrsp_req_id (mim_rrsp_req_id),
        .mim_rrsp_err    (mim_rrsp_err),
        .tqu_rsp_valid   (tqu_rsp_valid),
        .tqu_rsp_data    (tqu_rsp_data),
        .tqu_rsp_id      (tqu_rsp_id),
        .tqu_rsp_err     (tqu_rsp_err),
        .prc_rsp_valid   (prc_rsp_valid),
        .prc_rsp_id      (prc_rsp_id)
    );

    mesh_mem_bank i_mem_bank (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_wr_en       (mem_wr_en),
        .mem_wr_seg_ptr  (mem_wr_seg_ptr),
        .mem_wr_wd_sel   (mem_wr_wd_sel),
        .mem_wr_sema     (mem_wr_sema),
        .mem_wr_data     (mem_wr_data),
        .mim_rreq_valid  (mim_rreq_valid),
        .mim_seg_ptr     (mim_seg_ptr),
        .mim_sema        (mim_sema),
        .mim_wd_sel      (mim_wd_sel),
        .mim_req_id      (mim_req_id),
        .mim_rrsp_valid  (mim_rrsp_valid),
        .mim_rd_data     (mim_rd_data),
        .mim_rrsp_req_id (mim_rrsp_req_id),
        .mim_rrsp_err    (mim_rrsp_err)
    );

endmodule : egr_mesh_rd_top

`default_nettype wire

// File: logic/mesh_mem_bank.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_mem_bank (
    input  logic                              clk,
    input  logic                              rst_n,

    // Preload write port
    input  logic                              mem_wr_en,
    input  logic [mesh_rd_pkg::W_SEG_PTR-1:0] mem_wr_seg_ptr,
    input  logic [mesh_rd_pkg::W_WD_SEL-1:0]  mem_wr_wd_sel,
    input  logic [mesh_rd_pkg::W_SEMA-1:0]    mem_wr_sema,
    input  logic [mesh_rd_pkg::W_WORD-1:0]    mem_wr_data,

    // Read request from the mesh
    input  logic                              mim_rreq_valid,
    input  logic [mesh_rd_pkg::W_SEG_PTR-1:0] mim_seg_ptr,
    input  logic [mesh_rd_pkg::W_SEMA-1:0]    mim_sema,
    input  logic [mesh_rd_pkg::W_WD_SEL-1:0]  mim_wd_sel,
    input  logic [mesh_rd_pkg::W_REQ_ID-1:0]  mim_req_id,

    // Read response, MEM_LAT cycles later
    output logic                              mim_rrsp_valid,
    output logic [mesh_rd_pkg::W_WORD-1:0]    mim_rd_data,
    output logic [mesh_rd_pkg::W_REQ_ID-1:0]  mim_rrsp_req_id,
    output logic                              mim_rrsp_err
);

    import mesh_rd_pkg::*;

    //////////////////////////////
    // Storage
    //////////////////////////////
    logic [W_WORD-1:0]     word_mem [N_MEM_WORDS];  // Word array, no reset
    logic [W_SEMA-1:0]     sema_mem [N_SEGS];       // One tag per segment
    logic [W_MEM_ADDR-1:0] wr_addr;
    logic [W_MEM_ADDR-1:0] rd_addr;

    assign wr_addr = {mem_wr_seg_ptr, mem_wr_wd_sel};  // Pointer selects segment
    assign rd_addr = {mim_seg_ptr, mim_wd_sel};

    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            word_mem[wr_addr] <= mem_wr_data;
        end
    end

    // Preload also stamps the segment's semaphore
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < N_SEGS; s++) begin
                sema_mem[s] <= '0;
            end
        end else if (mem_wr_en) begin
            sema_mem[mem_wr_seg_ptr] <= mem_wr_sema;
        end
    end

    //////////////////////////////
    // Semaphore check
    //////////////////////////////
    logic              sema_hit;
    logic [W_WORD-1:0] rd_word;

    assign sema_hit = (mim_sema == sema_mem[mim_seg_ptr]);
    assign rd_word  = sema_hit ? word_mem[rd_addr] : '0;  // Stale tag reads zero

    //////////////////////////////
    // Read latency pipeline
    //////////////////////////////
    logic [MEM_LAT-1:0] vld_pipe;                   // Bit 0 loads first
    logic [W_WORD-1:0]  data_pipe [MEM_LAT];
    logic [W_REQ_ID-1:0] id_pipe  [MEM_LAT];
    logic [MEM_LAT-1:0] err_pipe;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[MEM_LAT-2:0], mim_rreq_valid};
        end
    end

    // Payload shifts freely, valid qualifies it
    always_ff @(posedge clk) begin
        data_pipe[0] <= rd_word;
        id_pipe[0]   <= mim_req_id;
        err_pipe[0]  <= !sema_hit;
        for (int i = 1; i < MEM_LAT; i++) begin
            data_pipe[i] <= data_pipe[i-1];
            id_pipe[i]   <= id_pipe[i-1];
            err_pipe[i]  <= err_pipe[i-1];
        end
    end

    assign mim_rrsp_valid  = vld_pipe[MEM_LAT-1];
    assign mim_rd_data     = data_pipe[MEM_LAT-1];
    assign mim_rrsp_req_id = id_pipe[MEM_LAT-1];
    assign mim_rrsp_err    = err_pipe[MEM_LAT-1];

endmodule : mesh_mem_bank

`default_nettype wire

// File: logic/mesh_rd_pkg.sv
`default_nettype none

package mesh_rd_pkg;

    //////////////////////////////
    // Request field widths
    //////////////////////////////
    localparam int W_SEG_PTR = 8;                   // Segment pointer
    localparam int W_WD_SEL  = 2;                   // Word within segment
    localparam int W_SEMA    = 2;                   // Semaphore tag per segment
    localparam int W_REQ_ID  = 6;                   // Request tag from controller

    // Packed request is {seg_ptr, sema, wd_sel, req_id}
    localparam int W_RREQ = W_SEG_PTR + W_SEMA + W_WD_SEL + W_REQ_ID;

    //////////////////////////////
    // Data path
    //////////////////////////////
    localparam int W_WORD = 64;                     // One mesh data word

    // Response tag is {req_id, err}
    localparam int W_RRSP_TAG = W_REQ_ID + 1;

    //////////////////////////////
    // FIFO geometry
    //////////////////////////////
    localparam int N_FIFO_ENTRIES = 4;              // Request and response FIFOs alike
    localparam int W_FIFO_ADDR    = $clog2(N_FIFO_ENTRIES);

    //////////////////////////////
    // Memory bank geometry
    //////////////////////////////
    localparam int N_SEGS        = 2 ** W_SEG_PTR;  // Segments in the bank
    localparam int N_WDS_PER_SEG = 2 ** W_WD_SEL;   // Words per segment
    localparam int N_MEM_WORDS   = N_SEGS * N_WDS_PER_SEG;
    localparam int W_MEM_ADDR    = $clog2(N_MEM_WORDS);

    // Cycles from request strobe to response strobe
    localparam int MEM_LAT = 3;

endpackage : mesh_rd_pkg

`default_nettype wire

// File: logic/mesh_rd_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_rd_unit (
    input  logic                              clk,
    input  logic                              rst_n,

    // Packet read controller requests
    input  logic                              rreq_valid,
    input  logic [mesh_rd_pkg::W_SEG_PTR-1:0] rreq_seg_ptr,
    input  logic [mesh_rd_pkg::W_SEMA-1:0]    rreq_sema,
    input  logic [mesh_rd_pkg::W_WD_SEL-1:0]  rreq_wd_sel,
    input  logic [mesh_rd_pkg::W_REQ_ID-1:0]  rreq_id,
    output logic                              rreq_full,     // Level, hold off strobes

    // Mesh memory request port
    output logic                              mim_rreq_valid,
    output logic [mesh_rd_pkg::W_SEG_PTR-1:0] mim_seg_ptr,
    output logic [mesh_rd_pkg::W_SEMA-1:0]    mim_sema,
    output logic [mesh_rd_pkg::W_WD_SEL-1:0]  mim_wd_sel,
    output logic [mesh_rd_pkg::W_REQ_ID-1:0]  mim_req_id,

    // Mesh memory response port
    input  logic                              mim_rrsp_valid,
    input  logic [mesh_rd_pkg::W_WORD-1:0]    mim_rd_data,
    input  logic [mesh_rd_pkg::W_REQ_ID-1:0]  mim_rrsp_req_id,
    input  logic                              mim_rrsp_err,

    // Transmit queue response
    output logic                              tqu_rsp_valid,
    output logic [mesh_rd_pkg::W_WORD-1:0]    tqu_rsp_data,
    output logic [mesh_rd_pkg::W_REQ_ID-1:0]  tqu_rsp_id,
    output logic                              tqu_rsp_err,

    // Controller tag retire notice
    output logic                              prc_rsp_valid,
    output logic [mesh_rd_pkg::W_REQ_ID-1:0]  prc_rsp_id
);

    import mesh_rd_pkg::*;

    //////////////////////////////
    // Read requests
    //////////////////////////////
    logic [W_RREQ-1:0] rreq_in;            // Packed request into FIFO
    logic [W_RREQ-1:0] rreq_head;          // Head of request FIFO
    logic              rreq_empty;
    logic              rreq_empty_reg;     // Empty as seen last cycle
    logic              rreq_pop;

    assign rreq_in = {rreq_seg_ptr, rreq_sema, rreq_wd_sel, rreq_id};

    rd_fifo #(
        .WIDTH  (W_RREQ),
        .ADDR_W (W_FIFO_ADDR)
    ) i_rreq_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (rreq_valid),
        .rd     (rreq_pop),
        .d_in   (rreq_in),
        .d_out  (rreq_head),
        .empty  (rreq_empty),
        .full   (rreq_full),
        .count  ()
    );

    // Pop only once the FIFO has been non-empty for a full cycle
    assign rreq_pop       = !rreq_empty_reg && !rreq_empty;
    assign mim_rreq_valid = rreq_pop;      // Pop doubles as the mesh strobe

    // Unpack head onto the mesh port
    assign {mim_seg_ptr, mim_sema, mim_wd_sel, mim_req_id} = rreq_head;

    //////////////////////////////
    // Read responses
    //////////////////////////////
    logic [W_RRSP_TAG-1:0] rrsp_tag_in;    // {req_id, err}
    logic [W_RRSP_TAG-1:0] rrsp_tag_head;
    logic                  rrsp_data_empty;
    logic                  rrsp_tag_empty;
    logic                  rrsp_empty;     // Both halves move together
    logic                  rrsp_empty_reg;
    logic                  rrsp_pop;

    assign rrsp_tag_in = {mim_rrsp_req_id, mim_rrsp_err};

    // Data and tag share strobe and pop so they never skew
    rd_fifo #(
        .WIDTH  (W_WORD),
        .ADDR_W (W_FIFO_ADDR)
    ) i_rrsp_data_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (mim_rrsp_valid),
        .rd     (rrsp_pop),
        .d_in   (mim_rd_data),
        .d_out  (tqu_rsp_data),
        .empty  (rrsp_data_empty),
        .full   (),                        // Drains as fast as it fills
        .count  ()
    );

    rd_fifo #(
        .WIDTH  (W_RRSP_TAG),
        .ADDR_W (W_FIFO_ADDR)
    ) i_rrsp_tag_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (mim_rrsp_valid),
        .rd     (rrsp_pop),
        .d_in   (rrsp_tag_in),
        .d_out  (rrsp_tag_head),
        .empty  (rrsp_tag_empty),
        .full   (),
        .count  ()
    );

    assign rrsp_empty = rrsp_data_empty || rrsp_tag_empty;
    assign rrsp_pop   = !rrsp_empty_reg && !rrsp_empty;

    // Same strobe and ID to both consumers
    assign tqu_rsp_valid              = rrsp_pop;
    assign {tqu_rsp_id, tqu_rsp_err}  = rrsp_tag_head;
    assign prc_rsp_valid              = rrsp_pop;
    assign prc_rsp_id                 = tqu_rsp_id;

    //////////////////////////////
    // Delayed empty copies
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rreq_empty_reg <= 1'b0;        // FIFOs start empty, so no pop anyway
            rrsp_empty_reg <= 1'b0;
        end else begin
            rreq_empty_reg <= rreq_empty;
            rrsp_empty_reg <= rrsp_empty;
        end
    end

endmodule : mesh_rd_unit

`default_nettype wire

// File: logic/rd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module rd_fifo #(
    parameter int WIDTH  = mesh_rd_pkg::W_WORD,       // Entry width
    parameter int ADDR_W = mesh_rd_pkg::W_FIFO_ADDR   // Pointer width, depth is 2**ADDR_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr,          // Push d_in
    input  logic              rd,          // Pop head
    input  logic [WIDTH-1:0]  d_in,
    output logic [WIDTH-1:0]  d_out,       // Head entry, fall-through
    output logic              empty,
    output logic              full,
    output logic [ADDR_W:0]   count        // Occupancy, 0 to depth
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [WIDTH-1:0]  mem [DEPTH];        // Entry storage, no reset
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic              wr_ok;              // Push that is actually taken
    logic              rd_ok;              // Pop that is actually taken

    // Overflow and underflow attempts are dropped
    assign wr_ok = wr && !full;
    assign rd_ok = rd && !empty;

    assign empty = (count == '0);
    assign full  = (count == (ADDR_W+1)'(DEPTH));
    assign d_out = mem[rd_ptr];            // Head visible without a pop

    //////////////////////////////
    // Pointers and occupancy
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop keeps the count
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage write
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= d_in;
        end
    end

endmodule : rd_fifo

`default_nettype wire

// File: verilog.f
logic/mesh_rd_pkg.sv
logic/rd_fifo.sv
logic/mesh_rd_unit.sv
logic/mesh_mem_bank.sv
logic/egr_mesh_rd_top.sv
bench/tb_mesh_rd.sv
